// File: common/shift_consts.svh
// ----------------------------
// Shift lane constants
// Sizes shared by the issue
// buffer, selector and top.
// ----------------------------

`ifndef SHIFT_CONSTS_SVH
`define SHIFT_CONSTS_SVH

// Number of issue buffer entries.
`define SHIFT_DP 4

// Data width of the integer datapath.
`define SHIFT_XLEN 64

// Architectural register count and index width.
`define SHIFT_NREG 32
`define SHIFT_REG_AW 5

// Width of a buffer index, never below one bit.
`define SHIFT_IDX_W (((`SHIFT_DP) > 1) ? $clog2(`SHIFT_DP) : 1)

`endif

// File: common/shift_isa_pkg.sv
// ----------------------------
// Shift ISA types
// Opcode encoding and the entry
// held in the issue buffer.
// ----------------------------

`include "shift_consts.svh"

package shift_isa_pkg;

	// The twelve RV64I shifts. Each function has reg, imm, reg-W and imm-W forms.
	typedef enum logic [3:0] {
		op_sll   = 4'd0,
		op_slli  = 4'd1,
		op_sllw  = 4'd2,
		op_slliw = 4'd3,
		op_srl   = 4'd4,
		op_srli  = 4'd5,
		op_srlw  = 4'd6,
		op_srliw = 4'd7,
		op_sra   = 4'd8,
		op_srai  = 4'd9,
		op_sraw  = 4'd10,
		op_sraiw = 4'd11
	} shift_op_e;

	// One dispatched instruction.
	typedef struct packed {
		shift_op_e op;
		logic [`SHIFT_REG_AW-1:0] rd;
		logic [`SHIFT_REG_AW-1:0] rs1;
		logic [`SHIFT_REG_AW-1:0] rs2;
		logic [5:0] shamt; // Only the imm forms use it.
	} shift_entry_t;

endpackage

// File: common/shift_pipe_pkg.sv
// ----------------------------
// Shift pipeline types
// Execute parameters and the
// write-back record.
// ----------------------------

`include "shift_consts.svh"

package shift_pipe_pkg;

	typedef enum logic [1:0] {
		fun_sll = 2'd0,
		fun_srl = 2'd1,
		fun_sra = 2'd2
	} shift_fun_e;

	// Operands are already resolved, so execute needs no register access.
	typedef struct packed {
		shift_fun_e fun;
		logic is32;
		logic [`SHIFT_REG_AW-1:0] rd;
		logic [`SHIFT_XLEN-1:0] op1;
		logic [`SHIFT_XLEN-1:0] op2;
	} shift_exeparam_t;

	typedef struct packed {
		logic [`SHIFT_REG_AW-1:0] rd;
		logic [`SHIFT_XLEN-1:0] data;
	} shift_wb_t;

endpackage

// File: hw/shift_issue/shift_issue_buffer.sv
// ----------------------------
// Shift issue buffer
// Stores dispatched shifts in
// the lowest free entry and
// frees entries on pop.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_issue_buffer (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,

	input  logic dispatch_valid,
	input  shift_isa_pkg::shift_entry_t dispatch_entry,

	input  logic pop,
	input  logic [`SHIFT_IDX_W-1:0] pop_index,

	output logic [`SHIFT_DP-1:0] entry_alloc,
	output shift_isa_pkg::shift_entry_t entries [`SHIFT_DP],
	output logic buffer_full
);

	logic [`SHIFT_IDX_W-1:0] free_index;
	logic do_write;

	// Scan from the top so the lowest free entry wins.
	always_comb begin
		free_index = '0;
		for (int i = `SHIFT_DP-1; i >= 0; i--) begin
			if (!entry_alloc[i]) begin
				free_index = `SHIFT_IDX_W'(i);
			end
		end
	end

	assign buffer_full = &entry_alloc;
	assign do_write = dispatch_valid & ~buffer_full & ~flush;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			entry_alloc <= '0;
		end else if (flush) begin
			entry_alloc <= '0; // Everything in flight is squashed.
		end else begin
			// Pop and dispatch never hit the same entry, one is allocated and one is free.
			if (pop) begin
				entry_alloc[pop_index] <= 1'b0;
			end
			if (do_write) begin
				entry_alloc[free_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (do_write) begin
			entries[free_index] <= dispatch_entry;
		end
	end

	a_no_dispatch_when_full: assert property (
		@(posedge CLK) disable iff (!rst_n) dispatch_valid |-> !buffer_full
	) else $error("dispatch while the issue buffer is full");

	a_pop_allocated: assert property (
		@(posedge CLK) disable iff (!rst_n) pop |-> entry_alloc[pop_index]
	) else $error("pop of an unallocated issue entry");

endmodule

// File: hw/shift_issue/shift_issue_slot.sv
// ----------------------------
// Shift issue slot
// RAW check and operand build
// for one buffer entry.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_issue_slot (
	input  logic alloc,
	input  shift_isa_pkg::shift_entry_t entry,
	input  logic [`SHIFT_NREG-1:0] reg_ready,
	input  logic [`SHIFT_XLEN-1:0] src1,
	input  logic [`SHIFT_XLEN-1:0] src2,
	output logic slot_ready,
	output shift_pipe_pkg::shift_exeparam_t slot_param
);

	shift_pipe_pkg::shift_fun_e fun;
	logic is32;
	logic is_imm;
	logic rs1_zero;
	logic rs2_zero;

	always_comb begin
		case (entry.op)
			shift_isa_pkg::op_sll, shift_isa_pkg::op_slli,
			shift_isa_pkg::op_sllw, shift_isa_pkg::op_slliw: fun = shift_pipe_pkg::fun_sll;
			shift_isa_pkg::op_srl, shift_isa_pkg::op_srli,
			shift_isa_pkg::op_srlw, shift_isa_pkg::op_srliw: fun = shift_pipe_pkg::fun_srl;
			default: fun = shift_pipe_pkg::fun_sra;
		endcase
		is32 = entry.op inside {shift_isa_pkg::op_sllw, shift_isa_pkg::op_slliw,
			shift_isa_pkg::op_srlw, shift_isa_pkg::op_srliw,
			shift_isa_pkg::op_sraw, shift_isa_pkg::op_sraiw};
		is_imm = entry.op inside {shift_isa_pkg::op_slli, shift_isa_pkg::op_slliw,
			shift_isa_pkg::op_srli, shift_isa_pkg::op_srliw,
			shift_isa_pkg::op_srai, shift_isa_pkg::op_sraiw};
	end

	assign rs1_zero = (entry.rs1 == '0);
	assign rs2_zero = (entry.rs2 == '0);

	// x0 is never busy, and the imm forms have no rs2 at all.
	assign slot_ready = alloc
		& (rs1_zero | reg_ready[entry.rs1])
		& (is_imm | rs2_zero | reg_ready[entry.rs2]);

	always_comb begin
		slot_param.fun = fun;
		slot_param.is32 = is32;
		slot_param.rd = entry.rd;
		slot_param.op1 = rs1_zero ? '0 : src1;
		if (is_imm) begin
			slot_param.op2 = {{(`SHIFT_XLEN-6){1'b0}}, entry.shamt};
		end else begin
			slot_param.op2 = rs2_zero ? '0 : src2;
		end
	end

endmodule

// File: hw/shift_issue/shift_issue_select.sv
// ----------------------------
// Shift issue selector
// Pops the lowest ready slot
// and registers its execute
// parameters.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_issue_select (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,

	input  logic [`SHIFT_DP-1:0] slot_ready,
	input  shift_pipe_pkg::shift_exeparam_t slot_param [`SHIFT_DP],

	output logic pop,
	output logic [`SHIFT_IDX_W-1:0] pop_index,

	output logic exe_valid,
	output shift_pipe_pkg::shift_exeparam_t exe_param
);

	// Issue order is by slot index only, age is not tracked.
	always_comb begin
		pop_index = '0;
		for (int i = `SHIFT_DP-1; i >= 0; i--) begin
			if (slot_ready[i]) begin
				pop_index = `SHIFT_IDX_W'(i);
			end
		end
	end

	// The shifter never stalls, so any ready slot issues at once.
	assign pop = (|slot_ready) & ~flush;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= pop; // Low after a flush, since pop is.
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_param <= slot_param[pop_index];
		end
	end

	// A popped slot must be freed by the buffer, so it never issues twice.
	a_pop_is_ready: assert property (
		@(posedge CLK) disable iff (!rst_n)
		pop |=> $past(slot_ready[pop_index]) && !slot_ready[$past(pop_index)]
	) else $error("popped slot was not ready or did not leave the buffer");

endmodule

// File: hw/shift_exec.sv
// ----------------------------
// Shift execute
// Barrel shifter for the full
// and word forms, with a
// registered write-back.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_exec (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,

	input  logic exe_valid,
	input  shift_pipe_pkg::shift_exeparam_t exe_param,

	output logic wb_valid,
	output shift_pipe_pkg::shift_wb_t wb
);

	logic [5:0] sh_full;
	logic [4:0] sh_word;
	logic [31:0] word;
	logic [`SHIFT_XLEN-1:0] full_res;
	logic [31:0] word_res;
	logic [`SHIFT_XLEN-1:0] result;

	always_comb begin
		sh_full = exe_param.op2[5:0];
		sh_word = exe_param.op2[4:0]; // Word forms ignore bit 5 of the amount.
		word = exe_param.op1[31:0];
		case (exe_param.fun)
			shift_pipe_pkg::fun_sll: begin
				full_res = exe_param.op1 << sh_full;
				word_res = word << sh_word;
			end
			shift_pipe_pkg::fun_srl: begin
				full_res = exe_param.op1 >> sh_full;
				word_res = word >> sh_word;
			end
			default: begin
				full_res = $signed(exe_param.op1) >>> sh_full;
				word_res = $signed(word) >>> sh_word; // Sign comes from bit 31.
			end
		endcase
		result = exe_param.is32 ? {{(`SHIFT_XLEN-32){word_res[31]}}, word_res} : full_res;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid & ~flush; // A flush drops the pending result.
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb.rd <= exe_param.rd;
			wb.data <= result;
		end
	end

endmodule

// File: hw/shift_regfile.sv
// ----------------------------
// Shift register file
// 32 x 64 registers with a
// write-back log of ready bits.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_regfile (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,

	input  logic load_valid,
	input  shift_pipe_pkg::shift_wb_t load_wb,

	input  logic wb_valid,
	input  shift_pipe_pkg::shift_wb_t wb,

	input  logic dispatch_valid,
	input  logic [`SHIFT_REG_AW-1:0] dispatch_rd,

	output logic [`SHIFT_XLEN-1:0] regs [`SHIFT_NREG],
	output logic [`SHIFT_NREG-1:0] reg_ready
);

	logic [`SHIFT_XLEN-1:0] regs_q [`SHIFT_NREG];
	logic [`SHIFT_NREG-1:0] ready_q;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int r = 0; r < `SHIFT_NREG; r++) begin
				regs_q[r] <= '0;
			end
			ready_q <= '1;
		end else begin
			if (wb_valid && wb.rd != '0) regs_q[wb.rd] <= wb.data;
			if (load_valid && load_wb.rd != '0) regs_q[load_wb.rd] <= load_wb.data;
			if (flush) begin
				ready_q <= '1; // Nothing is in flight after a flush.
			end else begin
				if (wb_valid) ready_q[wb.rd] <= 1'b1;
				if (load_valid) ready_q[load_wb.rd] <= 1'b1;
				// Later in the block, so a new producer wins over a retiring one.
				if (dispatch_valid && dispatch_rd != '0) ready_q[dispatch_rd] <= 1'b0;
			end
		end
	end

	// The write-back is forwarded while its strobe is high.
	// Consumers then see it in the same cycle the result leaves the lane.
	always_comb begin
		regs = regs_q;
		reg_ready = ready_q;
		if (wb_valid && wb.rd != '0) begin
			regs[wb.rd] = wb.data;
			reg_ready[wb.rd] = 1'b1;
		end
	end

endmodule

// File: hw/shift_unit_top.sv
// ----------------------------
// Shift unit top
// Issue buffer, slots, selector,
// shifter and register file.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_unit_top (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,

	input  logic dispatch_valid,
	input  shift_isa_pkg::shift_entry_t dispatch_entry,

	input  logic load_valid,
	input  shift_pipe_pkg::shift_wb_t load_wb,

	output logic buffer_full,
	output logic result_valid,
	output shift_pipe_pkg::shift_wb_t result
);

	logic [`SHIFT_DP-1:0] entry_alloc;
	shift_isa_pkg::shift_entry_t entries [`SHIFT_DP];
	logic [`SHIFT_XLEN-1:0] regs [`SHIFT_NREG];
	logic [`SHIFT_NREG-1:0] reg_ready;
	logic [`SHIFT_DP-1:0] slot_ready;
	shift_pipe_pkg::shift_exeparam_t slot_param [`SHIFT_DP];
	logic pop;
	logic [`SHIFT_IDX_W-1:0] pop_index;
	logic exe_valid;
	shift_pipe_pkg::shift_exeparam_t exe_param;

	shift_issue_buffer buffer_i (
		.CLK, .rst_n, .flush,
		.dispatch_valid, .dispatch_entry,
		.pop, .pop_index,
		.entry_alloc, .entries, .buffer_full
	);

	for (genvar i = 0; i < `SHIFT_DP; i++) begin : g_slot
		shift_issue_slot slot_i (
			.alloc(entry_alloc[i]),
			.entry(entries[i]),
			.reg_ready,
			.src1(regs[entries[i].rs1]),
			.src2(regs[entries[i].rs2]),
			.slot_ready(slot_ready[i]),
			.slot_param(slot_param[i])
		);
	end

	shift_issue_select select_i (
		.CLK, .rst_n, .flush,
		.slot_ready, .slot_param,
		.pop, .pop_index,
		.exe_valid, .exe_param
	);

	// The result port and the register file share the one write-back.
	shift_exec exec_i (
		.CLK, .rst_n, .flush,
		.exe_valid, .exe_param,
		.wb_valid(result_valid), .wb(result)
	);

	shift_regfile regfile_i (
		.CLK, .rst_n, .flush,
		.load_valid, .load_wb,
		.wb_valid(result_valid), .wb(result),
		.dispatch_valid(dispatch_valid & ~buffer_full),
		.dispatch_rd(dispatch_entry.rd),
		.regs, .reg_ready
	);

endmodule

// File: bench/shift_unit_tb.sv
// ----------------------------
// Shift unit testbench
// Table-driven shifts checked
// against a shadow-register
// model of the RV64I rules.
// ----------------------------

`timescale 1ns/1ps
`include "shift_consts.svh"

module shift_unit_tb;

	localparam int NROWS = 28;
	localparam int ROW_CYCLES = 40;
	localparam int RESET_CYCLES = 16;

	logic CLK = 1'b0;
	logic rst_n = 1'b0;
	logic flush = 1'b0;
	logic dispatch_valid = 1'b0;
	shift_isa_pkg::shift_entry_t dispatch_entry = '0;
	logic load_valid = 1'b0;
	shift_pipe_pkg::shift_wb_t load_wb = '0;
	logic buffer_full;
	logic result_valid;
	shift_pipe_pkg::shift_wb_t result;

	// Stimulus table. Rows 0-14 run alone, 15-18 form a chain, 19-25 fill the buffer.
	shift_isa_pkg::shift_op_e t_op [NROWS];
	logic [4:0] t_rs1 [NROWS];
	logic [4:0] t_rs2 [NROWS];
	logic [4:0] t_rd [NROWS];
	logic [5:0] t_shamt [NROWS];
	bit t_pre [NROWS];

	logic [63:0] shadow [`SHIFT_NREG];
	logic [4:0] res_rd [$];
	logic [63:0] res_data [$];
	int res_cyc [$];
	int cyc = 0;
	bit saw_full = 1'b0;
	integer seed = 32'h1c7f;

	shift_unit_top dut_i (
		.CLK, .rst_n, .flush,
		.dispatch_valid, .dispatch_entry,
		.load_valid, .load_wb,
		.buffer_full, .result_valid, .result
	);

	always #2 CLK = ~CLK;

	// Results are sampled on the rising edge, before the DUT updates them.
	always @(posedge CLK) begin
		if (rst_n && result_valid) begin
			res_rd.push_back(result.rd);
			res_data.push_back(result.data);
			res_cyc.push_back(cyc);
		end
		if (rst_n && buffer_full) saw_full = 1'b1;
		cyc++;
	end

	initial begin
		#((NROWS * ROW_CYCLES + RESET_CYCLES) * 4);
		$display("timeout, the shift unit stopped producing results");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1, "check on %s", name);
		end
	endtask

	// Register forms use rs2[5:0], and W forms keep 5 bits and sign-extend bit 31.
	function automatic logic [63:0] model_shift(input shift_isa_pkg::shift_op_e op,
			input logic [63:0] a, input logic [63:0] b, input logic [5:0] shamt);
		logic [5:0] amt;
		logic [31:0] wres;
		logic [63:0] res;
		bit imm;
		bit word;
		imm = op inside {shift_isa_pkg::op_slli, shift_isa_pkg::op_slliw,
			shift_isa_pkg::op_srli, shift_isa_pkg::op_srliw,
			shift_isa_pkg::op_srai, shift_isa_pkg::op_sraiw};
		word = op inside {shift_isa_pkg::op_sllw, shift_isa_pkg::op_slliw,
			shift_isa_pkg::op_srlw, shift_isa_pkg::op_srliw,
			shift_isa_pkg::op_sraw, shift_isa_pkg::op_sraiw};
		amt = imm ? shamt : b[5:0];
		if (op inside {shift_isa_pkg::op_sll, shift_isa_pkg::op_slli,
				shift_isa_pkg::op_sllw, shift_isa_pkg::op_slliw}) begin
			res = a << amt;
			wres = a[31:0] << amt[4:0];
		end else if (op inside {shift_isa_pkg::op_srl, shift_isa_pkg::op_srli,
				shift_isa_pkg::op_srlw, shift_isa_pkg::op_srliw}) begin
			res = a >> amt;
			wres = a[31:0] >> amt[4:0];
		end else begin
			res = $signed(a) >>> amt;
			wres = $signed(a[31:0]) >>> amt[4:0];
		end
		return word ? {{32{wres[31]}}, wres} : res;
	endfunction

	function automatic logic [63:0] expect_row(input int i);
		logic [63:0] e;
		e = model_shift(t_op[i], shadow[t_rs1[i]], shadow[t_rs2[i]], t_shamt[i]);
		if (t_rd[i] != 5'd0) shadow[t_rd[i]] = e;
		return e;
	endfunction

	task automatic set_row(input int i, input shift_isa_pkg::shift_op_e op, input int rd,
			input int rs1, input int rs2, input int shamt, input bit pre);
		t_op[i] = op;
		t_rd[i] = 5'(rd);
		t_rs1[i] = 5'(rs1);
		t_rs2[i] = 5'(rs2);
		t_shamt[i] = 6'(shamt);
		t_pre[i] = pre;
	endtask

	task automatic load_reg(input logic [4:0] r, input logic [63:0] v);
		@(negedge CLK);
		load_valid = 1'b1;
		load_wb.rd = r;
		load_wb.data = v;
		@(negedge CLK);
		load_valid = 1'b0;
		if (r != 5'd0) shadow[r] = v;
	endtask

	task automatic preload_row(input int i);
		if (t_pre[i] && t_rs1[i] != 5'd0) load_reg(t_rs1[i], {$random(seed), $random(seed)});
		if (t_pre[i] && t_rs2[i] != 5'd0 && t_rs2[i] != t_rs1[i])
			load_reg(t_rs2[i], {$random(seed), $random(seed)});
	endtask

	// Leaves the strobe high so rows can go out on back-to-back cycles.
	task automatic dispatch_row(input int i, output int t0);
		@(negedge CLK);
		while (buffer_full) begin
			dispatch_valid = 1'b0;
			@(negedge CLK);
		end
		dispatch_entry.op = t_op[i];
		dispatch_entry.rd = t_rd[i];
		dispatch_entry.rs1 = t_rs1[i];
		dispatch_entry.rs2 = t_rs2[i];
		dispatch_entry.shamt = t_shamt[i];
		dispatch_valid = 1'b1;
		t0 = cyc;
	endtask

	task automatic end_dispatch();
		@(negedge CLK);
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_results(input int n);
		int waited;
		waited = 0;
		while (res_rd.size() < n) begin
			if (waited == ROW_CYCLES) fail_run("expected result did not arrive in time");
			@(negedge CLK);
			waited++;
		end
	endtask

	// Runs one row alone and checks value, destination and the three-edge latency.
	task automatic run_single(input int i);
		int t0;
		logic [63:0] e;
		preload_row(i);
		dispatch_row(i, t0);
		e = expect_row(i);
		end_dispatch();
		wait_results(1);
		check_value("result.rd", 64'(res_rd.pop_front()), 64'(t_rd[i]));
		check_value("result.data", res_data.pop_front(), e);
		check_value("latency", 64'(res_cyc.pop_front() - t0), 64'd3);
		if (t_rd[i] == 5'd0) check_value("x0", dut_i.regfile_i.regs_q[0], 64'd0);
	endtask

	initial begin
		int t0;
		logic [63:0] e;
		logic [63:0] exp_by_rd [`SHIFT_NREG];
		bit pending [`SHIFT_NREG];
		logic [4:0] rd;
		for (int r = 0; r < `SHIFT_NREG; r++) begin
			shadow[r] = '0;
			pending[r] = 1'b0;
		end
		set_row(0, shift_isa_pkg::op_sll, 1, 2, 3, 0, 1);
		set_row(1, shift_isa_pkg::op_slli, 4, 5, 0, 'h3f, 1);
		set_row(2, shift_isa_pkg::op_sllw, 6, 7, 8, 0, 1);
		set_row(3, shift_isa_pkg::op_slliw, 9, 10, 0, 'h25, 1);
		set_row(4, shift_isa_pkg::op_srl, 1, 2, 3, 0, 1);
		set_row(5, shift_isa_pkg::op_srli, 4, 5, 0, 13, 1);
		set_row(6, shift_isa_pkg::op_srlw, 6, 7, 8, 0, 1);
		set_row(7, shift_isa_pkg::op_srliw, 9, 10, 0, 31, 1);
		set_row(8, shift_isa_pkg::op_sra, 1, 2, 3, 0, 1);
		set_row(9, shift_isa_pkg::op_srai, 4, 5, 0, 40, 1);
		set_row(10, shift_isa_pkg::op_sraw, 6, 7, 8, 0, 1);
		set_row(11, shift_isa_pkg::op_sraiw, 9, 10, 0, 'h21, 1);
		set_row(12, shift_isa_pkg::op_sll, 5, 0, 7, 0, 1);
		set_row(13, shift_isa_pkg::op_srl, 6, 8, 0, 0, 1);
		set_row(14, shift_isa_pkg::op_sraw, 0, 9, 10, 0, 1);
		set_row(15, shift_isa_pkg::op_slli, 11, 2, 0, 3, 0);
		set_row(16, shift_isa_pkg::op_sra, 12, 11, 3, 0, 0);
		set_row(17, shift_isa_pkg::op_sllw, 13, 12, 7, 0, 0);
		set_row(18, shift_isa_pkg::op_sraiw, 14, 13, 0, 7, 0);
		set_row(19, shift_isa_pkg::op_srli, 20, 4, 0, 5, 0);
		set_row(20, shift_isa_pkg::op_sll, 21, 20, 1, 0, 0);
		set_row(21, shift_isa_pkg::op_sraw, 22, 21, 2, 0, 0);
		set_row(22, shift_isa_pkg::op_slli, 23, 22, 0, 1, 0);
		set_row(23, shift_isa_pkg::op_srli, 24, 22, 0, 2, 0);
		set_row(24, shift_isa_pkg::op_srai, 25, 22, 0, 3, 0);
		set_row(25, shift_isa_pkg::op_slliw, 26, 22, 0, 4, 0);
		set_row(26, shift_isa_pkg::op_srl, 15, 16, 17, 0, 1);
		set_row(27, shift_isa_pkg::op_srai, 18, 15, 0, 9, 0);

		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		@(negedge CLK);
		check_value("result_valid", 64'(result_valid), 64'd0);
		check_value("buffer_full", 64'(buffer_full), 64'd0);

		for (int i = 0; i <= 14; i++) run_single(i);

		// Results of the dependent chain must come back in program order.
		for (int i = 15; i <= 18; i++) begin
			dispatch_row(i, t0);
			e = expect_row(i);
			exp_by_rd[t_rd[i]] = e;
		end
		end_dispatch();
		wait_results(4);
		for (int i = 15; i <= 18; i++) begin
			check_value("result.rd", 64'(res_rd.pop_front()), 64'(t_rd[i]));
			check_value("result.data", res_data.pop_front(), exp_by_rd[t_rd[i]]);
			void'(res_cyc.pop_front());
		end

		// Three producers hold the four readers of x22 until the buffer is full.
		saw_full = 1'b0;
		for (int i = 19; i <= 25; i++) begin
			dispatch_row(i, t0);
			exp_by_rd[t_rd[i]] = expect_row(i);
			pending[t_rd[i]] = 1'b1;
		end
		end_dispatch();
		wait_results(7);
		for (int k = 0; k < 7; k++) begin
			rd = res_rd.pop_front();
			if (!pending[rd]) fail_run($sformatf("result for x%0d was not expected", rd));
			pending[rd] = 1'b0;
			check_value("result.data", res_data.pop_front(), exp_by_rd[rd]);
			void'(res_cyc.pop_front());
		end
		if (!saw_full) fail_run("buffer_full never went high while the buffer was filled");

		// Flush right after dispatch squashes the write to x15.
		load_reg(5'd15, {$random(seed), $random(seed)});
		preload_row(26);
		dispatch_row(26, t0);
		@(negedge CLK);
		dispatch_valid = 1'b0;
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
		repeat (8) @(negedge CLK);
		if (res_rd.size() != 0) fail_run("a result appeared after the flush");
		run_single(27);

		$display("sim passed");
		$finish;
	end

endmodule

// File: src.f
+incdir+common
common/shift_isa_pkg.sv
common/shift_pipe_pkg.sv
hw/shift_issue/shift_issue_buffer.sv
hw/shift_issue/shift_issue_slot.sv
hw/shift_issue/shift_issue_select.sv
hw/shift_exec.sv
hw/shift_regfile.sv
hw/shift_unit_top.sv
bench/shift_unit_tb.sv

// File: Makefile
TOP := shift_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f src.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

lint:
	verilator --lint-only --timing -sv -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
